// ==== verilog.f ====
+incdir+hw
hw/bus_pkg.sv
hw/bus_link_if.sv
hw/addr_decoder.sv
hw/mem_target.sv
hw/resp_collector.sv
hw/bus_fabric_top.sv
verification/bus_fabric_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the bus fabric testbench with Verilator.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert --timescale 1ns/10ps \
    --top-module bus_fabric_tb -f verilog.f -o bus_fabric_sim \
    && ./obj_dir/bus_fabric_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Simulation did not build or run."; exit 1; }
cat sim.log
grep -q ">>> FAIL" sim.log && exit 1 || exit 0

// ==== verification/bus_fabric_tb.sv ====
`timescale 1ns/10ps

module bus_fabric_tb;
    import bus_pkg::*;

    localparam int clk_period = 100;
    localparam int reset_cycles = 5;
    localparam int idle_cycles = 8;
    localparam int ack_limit = 20;
    localparam int num_rows = 33;
    localparam int watchdog_ns = (num_rows * 20 + reset_cycles + idle_cycles) * clk_period;

    typedef struct packed {
        logic  rw;
        addr_t addr;
        data_t wdata;
        logic  exp_err;
        logic  rnd;
    } row_t;

    // Columns: rw, addr, wdata, expected err, random data.
    localparam row_t rows [num_rows] = '{
        '{1'b1, 16'h0000, 8'h00, 1'b0, 1'b1},
        '{1'b1, 16'h0400, 8'h00, 1'b0, 1'b1},
        '{1'b1, 16'h07FF, 8'h00, 1'b0, 1'b1},
        '{1'b1, 16'h4000, 8'h00, 1'b0, 1'b1},
        '{1'b1, 16'h4800, 8'h00, 1'b0, 1'b1},
        '{1'b1, 16'h4FFF, 8'h00, 1'b0, 1'b1},
        '{1'b1, 16'h8000, 8'h00, 1'b0, 1'b1},
        '{1'b1, 16'h8800, 8'h00, 1'b0, 1'b1},
        '{1'b1, 16'h8FFF, 8'h00, 1'b0, 1'b1},
        '{1'b0, 16'h0000, 8'h00, 1'b0, 1'b0},
        '{1'b0, 16'h0400, 8'h00, 1'b0, 1'b0},
        '{1'b0, 16'h07FF, 8'h00, 1'b0, 1'b0},
        '{1'b0, 16'h4000, 8'h00, 1'b0, 1'b0},
        '{1'b0, 16'h4800, 8'h00, 1'b0, 1'b0},
        '{1'b0, 16'h4FFF, 8'h00, 1'b0, 1'b0},
        '{1'b0, 16'h8000, 8'h00, 1'b0, 1'b0},
        '{1'b0, 16'h8800, 8'h00, 1'b0, 1'b0},
        '{1'b0, 16'h8FFF, 8'h00, 1'b0, 1'b0},
        // Same offset in every window.
        '{1'b1, 16'h0123, 8'hA5, 1'b0, 1'b0},
        '{1'b1, 16'h4123, 8'h5A, 1'b0, 1'b0},
        '{1'b1, 16'h8123, 8'hC3, 1'b0, 1'b0},
        '{1'b0, 16'h0123, 8'h00, 1'b0, 1'b0},
        '{1'b0, 16'h4123, 8'h00, 1'b0, 1'b0},
        '{1'b0, 16'h8123, 8'h00, 1'b0, 1'b0},
        // Holes in the map, each followed by a mapped neighbour.
        '{1'b1, 16'h0800, 8'hEE, 1'b1, 1'b0},
        '{1'b0, 16'h0000, 8'h00, 1'b0, 1'b0},
        '{1'b0, 16'h07FF, 8'h00, 1'b0, 1'b0},
        '{1'b0, 16'h3FFF, 8'h00, 1'b1, 1'b0},
        '{1'b0, 16'h4FFF, 8'h00, 1'b0, 1'b0},
        '{1'b1, 16'h5000, 8'hEE, 1'b1, 1'b0},
        '{1'b0, 16'h4000, 8'h00, 1'b0, 1'b0},
        '{1'b0, 16'hFFFF, 8'h00, 1'b1, 1'b0},
        '{1'b0, 16'h8FFF, 8'h00, 1'b0, 1'b0}
    };

    logic  clk = 1'b0;
    logic  rst_n;
    logic  req;
    logic  rw;
    addr_t addr;
    data_t wdata;
    logic  ack;
    logic  err;
    data_t rdata;

    logic [7:0] ref_mem [0:65535];
    integer     seed;
    integer     rnd_word;
    int         checks = 0;
    int         mismatches = 0;
    int         other_errors = 0;
    int         proto_errors = 0;
    logic       ack_d = 1'b0;

    bus_fabric_top u_bus_fabric_top (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .rw    (rw),
        .addr  (addr),
        .wdata (wdata),
        .ack   (ack),
        .err   (err),
        .rdata (rdata)
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            mismatches++;
            $display("mismatch at %0t: %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_byte(input string name, input data_t exp, input data_t act);
        checks++;
        if (act !== exp) begin
            mismatches++;
            $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    // One full four-phase transaction.
    task automatic run_row(input int r);
        row_t  row;
        data_t wd;
        data_t exp_rdata;
        int    cycles;
        row = rows[r];
        wd = row.wdata;
        if (row.rnd) begin
            rnd_word = $random(seed);
            wd = rnd_word[7:0];
        end
        @(posedge clk);
        req <= 1'b1;
        rw <= row.rw;
        addr <= row.addr;
        wdata <= wd;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (!ack && cycles < ack_limit);
        if (!ack) begin
            other_errors++;
            $display("error at %0t: row %0d got no ack within %0d cycles", $time, r, ack_limit);
        end else begin
            if (row.rw || row.exp_err) begin
                exp_rdata = '0;
            end else begin
                exp_rdata = ref_mem[row.addr];
            end
            check_bit("err", row.exp_err, err);
            check_byte("rdata", exp_rdata, rdata);
            if (row.rw && !row.exp_err) begin
                ref_mem[row.addr] = wd;
            end
        end
        req <= 1'b0;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (ack && cycles < ack_limit);
        if (ack) begin
            other_errors++;
            $display("error at %0t: row %0d kept ack high after req was lowered", $time, r);
        end
    endtask

    // Handshake order on the external port.
    always @(posedge clk) begin
        if (rst_n) begin
            if (ack && !ack_d && !req) begin
                proto_errors++;
                $display("error at %0t: ack rose while req was low", $time);
            end
            if (!ack && ack_d && req) begin
                proto_errors++;
                $display("error at %0t: ack fell while req was still high", $time);
            end
        end
        ack_d <= ack;
    end

    initial begin
        #(watchdog_ns);
        $display("error: timeout, the run did not finish within %0d ns", watchdog_ns);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        seed = 66;
        rst_n = 1'b0;
        req = 1'b0;
        rw = 1'b0;
        addr = '0;
        wdata = '0;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
        // Quiet bus after reset.
        repeat (idle_cycles) begin
            @(posedge clk);
            check_bit("ack", 1'b0, ack);
            check_bit("err", 1'b0, err);
        end
        for (int r = 0; r < num_rows; r++) begin
            run_row(r);
        end
        repeat (2) @(posedge clk);
        $display("checks %0d, mismatches %0d, other errors %0d",
                 checks, mismatches, other_errors + proto_errors);
        if (mismatches == 0 && other_errors == 0 && proto_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== hw/bus_fabric_top.sv ====
`timescale 1ns/10ps

module bus_fabric_top (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           req,
    input  logic           rw,
    input  bus_pkg::addr_t addr,
    input  bus_pkg::data_t wdata,
    output logic           ack,
    output logic           err,
    output bus_pkg::data_t rdata
);
    import bus_pkg::*;

    logic miss_req;
    logic miss_ack;

    // One link per target.
    bus_link_if links [num_targets] ();

    addr_decoder u_addr_decoder (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .rw       (rw),
        .addr     (addr),
        .wdata    (wdata),
        .links    (links),
        .miss_req (miss_req),
        .miss_ack (miss_ack)
    );

    // Memory size follows the window.
    for (genvar i = 0; i < num_targets; i++) begin : g_target
        mem_target #(
            .ADDR_BITS (win_addr_bits[i])
        ) u_mem_target (
            .clk   (clk),
            .rst_n (rst_n),
            .link  (links[i])
        );
    end

    resp_collector u_resp_collector (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .links    (links),
        .miss_req (miss_req),
        .miss_ack (miss_ack),
        .ack      (ack),
        .err      (err),
        .rdata    (rdata)
    );

endmodule

// ==== hw/resp_collector.sv ====
`timescale 1ns/10ps

module resp_collector (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           req,
    bus_link_if.monitor    links [bus_pkg::num_targets],
    input  logic           miss_req,
    output logic           miss_ack,
    output logic           ack,
    output logic           err,
    output bus_pkg::data_t rdata
);
    import bus_pkg::*;

    logic [num_targets-1:0] link_ack;
    data_t                  link_rdata [num_targets];
    data_t                  merged;
    logic                   any_src;
    logic                   ack_next;

    for (genvar i = 0; i < num_targets; i++) begin : g_link
        assign link_ack[i] = links[i].ack;
        assign link_rdata[i] = links[i].rdata;
    end

    // Only the acknowledging link contributes.
    always_comb begin
        merged = '0;
        for (int i = 0; i < num_targets; i++) begin
            if (link_ack[i]) begin
                merged = merged | link_rdata[i];
            end
        end
    end

    assign any_src = (|link_ack) || miss_ack;

    // Hold ack until req drops and every source is quiet.
    assign ack_next = any_src || (ack && req);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            miss_ack <= 1'b0;
            ack <= 1'b0;
            err <= 1'b0;
        end else begin
            miss_ack <= miss_req;
            ack <= ack_next;
            if (any_src) begin
                err <= miss_ack;
            end else if (!ack_next) begin
                err <= 1'b0;
            end
        end
    end

    // Miss leaves merged at zero.
    always_ff @(posedge clk) begin
        if (any_src) begin
            rdata <= merged;
        end
    end

    a_one_link_ack : assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0(link_ack)
    );

endmodule

// ==== hw/mem_target.sv ====
`timescale 1ns/10ps
`include "bus_settings.svh"

module mem_target #(
    parameter int ADDR_BITS = 12
) (
    input  logic       clk,
    input  logic       rst_n,
    bus_link_if.target link
);
    import bus_pkg::*;

    localparam int LAT = `BUS_TARGET_LATENCY;
    localparam int CNT_W = (LAT > 1) ? $clog2(LAT) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(LAT - 1);

    data_t                mem [2**ADDR_BITS];
    logic                 busy;
    logic [CNT_W-1:0]     cnt;
    logic                 ack_q;
    data_t                rdata_q;
    logic                 access;
    logic [ADDR_BITS-1:0] idx;

    assign idx = link.offset[ADDR_BITS-1:0];

    // Last wait cycle.
    assign access = busy && (cnt == CNT_LAST);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            cnt <= '0;
            ack_q <= 1'b0;
        end else begin
            if (!busy && !ack_q && link.req) begin
                busy <= 1'b1;
                cnt <= '0;
            end else if (access) begin
                busy <= 1'b0;
                ack_q <= 1'b1;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
            end
            // Return to idle once the request is withdrawn.
            if (ack_q && !link.req) begin
                ack_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            if (link.rw) begin
                mem[idx] <= link.wdata;
            end
            rdata_q <= link.rw ? '0 : mem[idx];
        end
    end

    assign link.ack = ack_q;
    assign link.rdata = rdata_q;

    // Acknowledge only a live request.
    a_ack_needs_req : assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(link.ack) |-> link.req
    );

endmodule

// ==== hw/addr_decoder.sv ====
`timescale 1ns/10ps

module addr_decoder (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           req,
    input  logic           rw,
    input  bus_pkg::addr_t addr,
    input  bus_pkg::data_t wdata,
    bus_link_if.initiator  links [bus_pkg::num_targets],
    output logic           miss_req,
    input  logic           miss_ack
);
    import bus_pkg::*;

    logic                   busy;
    logic                   hit_q;
    tgt_idx_t               sel_q;
    logic [num_targets-1:0] link_req_q;
    addr_t                  offset_q;
    logic                   rw_q;
    data_t                  wdata_q;
    logic [num_targets-1:0] link_ack;
    logic                   hit;
    tgt_idx_t               hit_idx;
    logic                   src_ack;

    // Window match.
    always_comb begin
        hit = 1'b0;
        hit_idx = '0;
        for (int i = 0; i < num_targets; i++) begin
            if (!hit && ({1'b0, addr} >= {1'b0, win_base[i]}) &&
                ({1'b0, addr} < ({1'b0, win_base[i]} + win_size[i]))) begin
                hit = 1'b1;
                hit_idx = tgt_idx_t'(i);
            end
        end
    end

    // The source that will answer this transaction.
    assign src_ack = hit_q ? link_ack[sel_q] : miss_ack;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            hit_q <= 1'b0;
            sel_q <= '0;
            link_req_q <= '0;
            miss_req <= 1'b0;
        end else if (!busy) begin
            if (req) begin
                busy <= 1'b1;
                hit_q <= hit;
                sel_q <= hit_idx;
                link_req_q <= '0;
                if (hit) begin
                    link_req_q[hit_idx] <= 1'b1;
                end
                miss_req <= !hit;
            end
        end else if (!req) begin
            link_req_q <= '0;
            miss_req <= 1'b0;
            // Wait for the answering side to close its phase.
            if (!src_ack) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && req) begin
            offset_q <= addr - win_base[hit_idx];
            rw_q <= rw;
            wdata_q <= wdata;
        end
    end

    for (genvar i = 0; i < num_targets; i++) begin : g_link
        assign links[i].req = link_req_q[i];
        assign links[i].rw = rw_q;
        assign links[i].offset = offset_q;
        assign links[i].wdata = wdata_q;
        assign link_ack[i] = links[i].ack;
    end

    // Only the selected destination answers.
    a_one_dest : assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0({link_ack, miss_ack}) &&
        (!(|link_ack) || (hit_q && link_ack[sel_q])) &&
        (!miss_ack || !hit_q)
    );

endmodule

// ==== hw/bus_link_if.sv ====
`timescale 1ns/10ps

interface bus_link_if;
    import bus_pkg::*;

    logic  req;
    logic  rw;
    addr_t offset;
    data_t wdata;
    logic  ack;
    data_t rdata;

    modport initiator (
        output req,
        output rw,
        output offset,
        output wdata,
        input  ack
    );

    modport target (
        input  req,
        input  rw,
        input  offset,
        input  wdata,
        output ack,
        output rdata
    );

    modport monitor (
        input ack,
        input rdata
    );

endinterface

// ==== hw/bus_pkg.sv ====
`include "bus_settings.svh"

package bus_pkg;

    localparam int num_targets = `BUS_NUM_TARGETS;

    typedef logic [`BUS_ADDR_W-1:0] addr_t;
    typedef logic [`BUS_DATA_W-1:0] data_t;
    typedef logic [$clog2(num_targets)-1:0] tgt_idx_t;

    // Window base per target.
    localparam addr_t win_base [num_targets] = '{
        `BUS_T0_BASE,
        `BUS_T1_BASE,
        `BUS_T2_BASE
    };

    // One bit wider than an address, so a full 64K window fits.
    localparam logic [`BUS_ADDR_W:0] win_size [num_targets] = '{
        (`BUS_ADDR_W+1)'(`BUS_T0_SIZE),
        (`BUS_ADDR_W+1)'(`BUS_T1_SIZE),
        (`BUS_ADDR_W+1)'(`BUS_T2_SIZE)
    };

    // Memory address width of each target.
    localparam int win_addr_bits [num_targets] = '{
        $clog2(`BUS_T0_SIZE),
        $clog2(`BUS_T1_SIZE),
        $clog2(`BUS_T2_SIZE)
    };

endpackage

// ==== hw/bus_settings.svh ====
`ifndef BUS_SETTINGS_SVH
`define BUS_SETTINGS_SVH

// Bus widths.
`define BUS_ADDR_W 16
`define BUS_DATA_W 8

// Number of memory targets on the bus.
`define BUS_NUM_TARGETS 3

// Window bases.
`define BUS_T0_BASE 16'h0000
`define BUS_T1_BASE 16'h4000
`define BUS_T2_BASE 16'h8000

// Window sizes in bytes.
`define BUS_T0_SIZE 2048
`define BUS_T1_SIZE 4096
`define BUS_T2_SIZE 4096

// Wait cycles a target inserts before it acknowledges.
`define BUS_TARGET_LATENCY 2

`endif
